// File: project.f
rtl/imu_pkg.sv
rtl/spi_cmd_if.sv
rtl/poll_tick.sv
rtl/spi_master.sv
rtl/axis_capture.sv
rtl/poll_sequencer.sv
rtl/imu_poller_top.sv
verification/spi_sensor_model.sv
verification/imu_poller_properties.sv
verification/imu_poller_tb.sv

// File: run.sh
#!/bin/sh
# build and run the imu poller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module imu_poller_tb \
    -f project.f \
    -o imu_poller_sim

# keep running past assertion errors so the testbench prints its status
./obj_dir/imu_poller_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: verification/imu_poller_tb.sv
`timescale 1ns/100ps

module imu_poller_tb
    import imu_pkg::*;
();

    localparam int TICK_DIV    = 200;
    localparam int NUM_TESTS   = 5;
    localparam int FRAME_LIMIT = TICK_DIV + 3000;               // cycles per test
    localparam int WATCHDOG_NS = NUM_TESTS * FRAME_LIMIT * 8;   // 8 ns clock

    logic              clk = 1'b0;
    logic              reset_top;
    logic              btnc;
    logic              sck_0, cs_n_0, mosi_0, miso_0;           // accel channel
    logic              sck_1, cs_n_1, mosi_1, miso_1;           // gyro channel
    logic [AXIS_W-1:0] accel_x, accel_y, accel_z;
    logic [AXIS_W-1:0] gyro_x, gyro_y, gyro_z;
    logic              accel_valid, gyro_valid;
    logic [47:0]       accel_regs;                              // register n at [8n +: 8]
    logic [47:0]       gyro_regs;
    int                accel_hdr_errors;
    int                gyro_hdr_errors;
    int                seed       = 32'h0036acb9;
    int                mismatches = 0;
    int                failures   = 0;                          // timeouts, bad headers
    int                assert_hits;

    always #4 clk = ~clk;

    imu_poller_top #(.TICK_DIV(TICK_DIV)) imu_poller_top_i (
        .clk(clk), .reset_top(reset_top), .btnc(btnc),
        .sck_0(sck_0), .cs_n_0(cs_n_0), .mosi_0(mosi_0), .miso_0(miso_0),
        .sck_1(sck_1), .cs_n_1(cs_n_1), .mosi_1(mosi_1), .miso_1(miso_1),
        .accel_x(accel_x), .accel_y(accel_y), .accel_z(accel_z),
        .gyro_x(gyro_x), .gyro_y(gyro_y), .gyro_z(gyro_z),
        .accel_valid(accel_valid), .gyro_valid(gyro_valid)
    );

    // accel header is 0x0B then 0x0E + n
    // gyro header is 0x80 + 0x28 + n
    spi_sensor_model #(.LONG_HEADER(1'b1), .OPCODE(8'h0B), .BASE(8'h0E)) accel_model_i (
        .sck(sck_0), .cs_n(cs_n_0), .mosi(mosi_0), .miso(miso_0),
        .reg_bytes(accel_regs), .header_errors(accel_hdr_errors)
    );

    spi_sensor_model #(.LONG_HEADER(1'b0), .OPCODE(8'h00), .BASE(8'h80 + 8'h28)) gyro_model_i (
        .sck(sck_1), .cs_n(cs_n_1), .mosi(mosi_1), .miso(miso_1),
        .reg_bytes(gyro_regs), .header_errors(gyro_hdr_errors)
    );

    ////////////////////////////////////////////////////////////////////////////
    // compare helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_axis(input string name, input logic [AXIS_W-1:0] actual,
                                input logic [AXIS_W-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            mismatches++;
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            mismatches++;
        end
    endtask

    // axis k = register 2k+1 (high byte) over register 2k (low byte)
    function automatic logic [AXIS_W-1:0] expect_axis(input logic [47:0] regs, input int k);
        return {regs[8*(2*k+1) +: 8], regs[8*(2*k) +: 8]};
    endfunction

    task automatic load_model_bytes();
        for (int n = 0; n < 6; n++) begin
            accel_regs[8*n +: 8] = 8'($random(seed));
            gyro_regs[8*n +: 8]  = 8'($random(seed));
        end
    endtask

    task automatic wait_for_valid(input bit gyro);
        int cycles;
        cycles = 0;
        while ((gyro ? gyro_valid : accel_valid) !== 1'b1 && cycles < FRAME_LIMIT) begin
            @(negedge clk);                     // outputs settled mid cycle
            cycles++;
        end
        if ((gyro ? gyro_valid : accel_valid) !== 1'b1) begin
            $display("%s frame did not finish within %0d cycles",
                     gyro ? "gyroscope" : "accelerometer", FRAME_LIMIT);
            failures++;
        end
    endtask

    // first accel transfer marks the frame start
    task automatic wait_for_frame_start();
        int cycles;
        cycles = 0;
        while (cs_n_0 !== 1'b0 && cycles < FRAME_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cs_n_0 !== 1'b0) begin
            $display("accelerometer frame did not start within %0d cycles", FRAME_LIMIT);
            failures++;
        end
    endtask

    task automatic check_channel(input bit gyro);
        if (gyro) begin
            compare_flag("gyro_valid", gyro_valid, 1'b1);
            compare_axis("gyro_x", gyro_x, expect_axis(gyro_regs, 0));
            compare_axis("gyro_y", gyro_y, expect_axis(gyro_regs, 1));
            compare_axis("gyro_z", gyro_z, expect_axis(gyro_regs, 2));
        end else begin
            compare_flag("accel_valid", accel_valid, 1'b1);
            compare_axis("accel_x", accel_x, expect_axis(accel_regs, 0));
            compare_axis("accel_y", accel_y, expect_axis(accel_regs, 1));
            compare_axis("accel_z", accel_z, expect_axis(accel_regs, 2));
        end
        if (accel_hdr_errors != 0 || gyro_hdr_errors != 0) begin
            $display("sensor models saw bad spi headers: accel %0d, gyro %0d",
                     accel_hdr_errors, gyro_hdr_errors);
            failures++;
        end
    endtask

    task automatic compare_axes_zero();
        compare_axis("accel_x", accel_x, '0);
        compare_axis("accel_y", accel_y, '0);
        compare_axis("accel_z", accel_z, '0);
        compare_axis("gyro_x", gyro_x, '0);
        compare_axis("gyro_y", gyro_y, '0);
        compare_axis("gyro_z", gyro_z, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        compare_flag("accel_valid", accel_valid, 1'b0);
        compare_flag("gyro_valid", gyro_valid, 1'b0);
        compare_flag("cs_n_0", cs_n_0, 1'b1);
        compare_flag("cs_n_1", cs_n_1, 1'b1);
        compare_flag("sck_0", sck_0, 1'b0);
        compare_flag("sck_1", sck_1, 1'b0);
        compare_axes_zero();
    endtask

    task automatic accel_frame();
        wait_for_valid(1'b0);
        check_channel(1'b0);
    endtask

    task automatic gyro_frame();
        wait_for_valid(1'b1);                   // shorter header, done first
        check_channel(1'b1);
    endtask

    task automatic hold_through_ticks();
        logic [AXIS_W-1:0] held [6];
        int                cs_low;
        held[0] = accel_x;
        held[1] = accel_y;
        held[2] = accel_z;
        held[3] = gyro_x;
        held[4] = gyro_y;
        held[5] = gyro_z;
        cs_low  = 0;
        repeat (3 * TICK_DIV) begin             // three more ticks go by unused
            @(negedge clk);
            if (!cs_n_0 || !cs_n_1) cs_low++;
        end
        if (cs_low != 0) begin
            $display("chip select went low for %0d cycles while frames were held", cs_low);
            failures++;
        end
        compare_flag("accel_valid", accel_valid, 1'b1);
        compare_flag("gyro_valid", gyro_valid, 1'b1);
        compare_axis("accel_x", accel_x, held[0]);
        compare_axis("accel_y", accel_y, held[1]);
        compare_axis("accel_z", accel_z, held[2]);
        compare_axis("gyro_x", gyro_x, held[3]);
        compare_axis("gyro_y", gyro_y, held[4]);
        compare_axis("gyro_z", gyro_z, held[5]);
    endtask

    task automatic rearm_and_repoll();
        load_model_bytes();                     // both sequencers sit in DONE
        @(posedge clk);
        btnc <= 1'b1;
        @(posedge clk);
        btnc <= 1'b0;
        @(negedge clk);                         // back in IDLE by now
        compare_flag("accel_valid", accel_valid, 1'b0);
        compare_flag("gyro_valid", gyro_valid, 1'b0);
        wait_for_frame_start();
        compare_axes_zero();                    // cleared before the first byte lands
        accel_frame();
        gyro_frame();
    endtask

    initial begin
        reset_top = 1'b1;
        btnc      = 1'b0;
        load_model_bytes();
        repeat (3) @(posedge clk);
        reset_top <= 1'b0;
        @(negedge clk);
        check_reset_state();
        accel_frame();
        gyro_frame();
        hold_through_ticks();
        rearm_and_repoll();
        assert_hits = imu_poller_top_i.props_0_i.assert_failures
                    + imu_poller_top_i.props_1_i.assert_failures;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, assert_hits);
        if (mismatches == 0 && failures == 0 && assert_hits == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // stuck frame guard
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verification/imu_poller_properties.sv
`timescale 1ns/100ps

// handshake and valid rules for one channel
module imu_poller_properties (
    input logic clk,
    input logic reset_top,
    input logic start,
    input logic ready,
    input logic cs_n,
    input logic sck,
    input logic valid
);

    int assert_failures = 0;    // hits over the whole run

    // master must be ready when start comes and drop ready right after
    start_when_ready: assert property (@(posedge clk) disable iff (reset_top)
        start |=> !ready && $past(ready))
        else begin
            $error("start not taken by a ready spi master");
            assert_failures++;
        end

    // idle master keeps the chip deselected and sck parked low
    ready_keeps_cs_high: assert property (@(posedge clk) disable iff (reset_top)
        ready |-> cs_n && !sck)
        else begin
            $error("spi bus active while the spi master reports ready");
            assert_failures++;
        end

    no_start_when_valid: assert property (@(posedge clk) disable iff (reset_top)
        valid |-> !start && cs_n)
        else begin
            $error("spi transfer while the frame was still valid");
            assert_failures++;
        end

endmodule

// one checker per channel
bind imu_poller_top imu_poller_properties props_0_i (
    .clk(clk), .reset_top(reset_top), .start(cmd_if_0.start),
    .ready(cmd_if_0.ready), .cs_n(cs_n_0), .sck(sck_0), .valid(accel_valid)
);

bind imu_poller_top imu_poller_properties props_1_i (
    .clk(clk), .reset_top(reset_top), .start(cmd_if_1.start),
    .ready(cmd_if_1.ready), .cs_n(cs_n_1), .sck(sck_1), .valid(gyro_valid)
);

// File: verification/spi_sensor_model.sv
`timescale 1ns/100ps

// mode 0 spi slave, answers one register byte per transfer
module spi_sensor_model #(
    parameter bit         LONG_HEADER = 1'b1,   // 1: opcode + address, 0: one header byte
    parameter logic [7:0] OPCODE      = 8'h0B,  // upper header byte, long header only
    parameter logic [7:0] BASE        = 8'h0E   // header byte that selects register 0
) (
    input  logic        sck,
    input  logic        cs_n,
    input  logic        mosi,
    output logic        miso,
    input  logic [47:0] reg_bytes,              // register n at [8n +: 8]
    output int          header_errors
);

    localparam int HDR_BITS = LONG_HEADER ? 16 : 8;

    logic [15:0] hdr_sr;
    logic [7:0]  out_sr;
    logic [7:0]  reg_idx;

    initial begin
        miso          = 1'b0;
        header_errors = 0;
        forever begin
            @(negedge cs_n);                    // transfer begins
            hdr_sr = '0;
            for (int i = 0; i < HDR_BITS; i++) begin
                @(posedge sck);
                hdr_sr = {hdr_sr[14:0], mosi};  // msb first
            end
            reg_idx = hdr_sr[7:0] - BASE;
            if ((LONG_HEADER && hdr_sr[15:8] != OPCODE) || reg_idx >= 8'd6) begin
                header_errors = header_errors + 1;
                out_sr        = 8'h00;          // unknown register reads as zero
            end else begin
                out_sr = reg_bytes[8*reg_idx +: 8];
            end
            // data changes on the falling edge, master samples on the rise
            repeat (8) begin
                @(negedge sck);
                miso   = out_sr[7];
                out_sr = {out_sr[6:0], 1'b0};
            end
        end
    end

endmodule

// File: rtl/imu_poller_top.sv
`timescale 1ns/100ps

module imu_poller_top
    import imu_pkg::*;
#(
    parameter int TICK_DIV = TICK_DIV_DEFAULT
) (
    input  logic              clk,
    input  logic              reset_top,
    input  logic              btnc,          // rearm both channels
    // channel 0, accelerometer
    output logic              sck_0,
    output logic              cs_n_0,
    output logic              mosi_0,
    input  logic              miso_0,
    // channel 1, gyroscope
    output logic              sck_1,
    output logic              cs_n_1,
    output logic              mosi_1,
    input  logic              miso_1,
    output logic [AXIS_W-1:0] accel_x,
    output logic [AXIS_W-1:0] accel_y,
    output logic [AXIS_W-1:0] accel_z,
    output logic [AXIS_W-1:0] gyro_x,
    output logic [AXIS_W-1:0] gyro_y,
    output logic [AXIS_W-1:0] gyro_z,
    output logic              accel_valid,
    output logic              gyro_valid
);

    logic       tick;
    logic       clear_0, clear_1;
    logic       we_0, we_1;
    logic [2:0] sel_0, sel_1;

    spi_cmd_if cmd_if_0 ();
    spi_cmd_if cmd_if_1 ();

    poll_tick #(.TICK_DIV(TICK_DIV)) poll_tick_i (
        .clk(clk), .reset_top(reset_top), .tick(tick)
    );

    ////////////////////////////////////////////////////////////////////////////
    // channel 0, accelerometer
    ////////////////////////////////////////////////////////////////////////////

    poll_sequencer #(.ACCEL_SENSOR(1'b1)) seq_0_i (
        .clk(clk), .reset_top(reset_top), .tick(tick), .rearm(btnc),
        .cmd_port(cmd_if_0.seq), .clear(clear_0), .byte_we(we_0),
        .byte_sel(sel_0), .valid(accel_valid)
    );

    spi_master spi_0_i (
        .clk(clk), .reset_top(reset_top), .cmd_port(cmd_if_0.master),
        .sck(sck_0), .cs_n(cs_n_0), .mosi(mosi_0), .miso(miso_0)
    );

    axis_capture cap_0_i (
        .clk(clk), .reset_top(reset_top), .clear(clear_0), .byte_we(we_0),
        .byte_sel(sel_0), .byte_in(cmd_if_0.rx_byte),
        .axis_x(accel_x), .axis_y(accel_y), .axis_z(accel_z)
    );

    ////////////////////////////////////////////////////////////////////////////
    // channel 1, gyroscope
    ////////////////////////////////////////////////////////////////////////////

    poll_sequencer #(.ACCEL_SENSOR(1'b0)) seq_1_i (
        .clk(clk), .reset_top(reset_top), .tick(tick), .rearm(btnc),
        .cmd_port(cmd_if_1.seq), .clear(clear_1), .byte_we(we_1),
        .byte_sel(sel_1), .valid(gyro_valid)
    );

    spi_master spi_1_i (
        .clk(clk), .reset_top(reset_top), .cmd_port(cmd_if_1.master),
        .sck(sck_1), .cs_n(cs_n_1), .mosi(mosi_1), .miso(miso_1)
    );

    axis_capture cap_1_i (
        .clk(clk), .reset_top(reset_top), .clear(clear_1), .byte_we(we_1),
        .byte_sel(sel_1), .byte_in(cmd_if_1.rx_byte),
        .axis_x(gyro_x), .axis_y(gyro_y), .axis_z(gyro_z)
    );

endmodule

// File: rtl/poll_sequencer.sv
`timescale 1ns/100ps

// walks the six axis registers of one sensor per frame
module poll_sequencer
    import imu_pkg::*;
#(
    parameter bit ACCEL_SENSOR = 1'b1   // 1 = accel command format, 0 = gyro
) (
    input  logic   clk,
    input  logic   reset_top,
    input  logic   tick,            // frame timebase
    input  logic   rearm,           // button, DONE -> IDLE
    spi_cmd_if.seq cmd_port,
    output logic   clear,
    output logic   byte_we,
    output logic   [2:0] byte_sel,
    output logic   valid
);

    logic [1:0]       state;
    logic [1:0]       next_state;
    logic [SEL_W-1:0] idx;              // which of the six registers
    logic             ready_q;          // for ready edge detect

    wire ready_rise = cmd_port.ready & ~ready_q;
    wire last_byte  = (idx == SEL_W'(AXIS_BYTES - 1));

    assign clear    = (state == ST_IDLE) && tick;   // cycle the frame starts
    assign byte_sel = idx;                          // idx only moves after the write
    assign valid    = (state == ST_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // command word for the current register
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        cmd_port.start = (state == ST_ISSUE) && cmd_port.ready;
        if (ACCEL_SENSOR) begin
            cmd_port.cmd.accel.opcode = ACCEL_READ_OP;
            cmd_port.cmd.accel.addr   = ACCEL_BASE_ADDR + {5'd0, idx};
            cmd_port.long_header      = 1'b1;    // opcode + address
        end else begin
            cmd_port.cmd.gyro.rd   = 1'b1;
            cmd_port.cmd.gyro.ms   = 1'b0;       // single register per transfer
            cmd_port.cmd.gyro.addr = GYRO_BASE_ADDR + {3'd0, idx};
            cmd_port.cmd.gyro.pad  = '0;
            cmd_port.long_header   = 1'b0;       // one header byte
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;                      // hold by default
        case (state)
            ST_IDLE:  if (tick) next_state = ST_ISSUE;
            ST_ISSUE: if (cmd_port.ready) next_state = ST_WAIT;   // start goes out now
            ST_WAIT: begin
                // leave once the byte write has been issued
                if (byte_we) begin
                    next_state = last_byte ? ST_DONE : ST_ISSUE;
                end
            end
            ST_DONE:  if (rearm) next_state = ST_IDLE;
            default:  next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_top) begin
            state   <= ST_IDLE;
            idx     <= '0;
            byte_we <= 1'b0;
            ready_q <= 1'b1;                     // master comes out of reset ready
        end else begin
            state   <= next_state;
            ready_q <= cmd_port.ready;
            byte_we <= (state == ST_WAIT) && ready_rise;   // cycle after ready rises
            if (clear) begin
                idx <= '0;                       // new frame starts at x low
            end else if (state == ST_WAIT && byte_we && !last_byte) begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// File: rtl/axis_capture.sv
`timescale 1ns/100ps

module axis_capture
    import imu_pkg::*;
(
    input  logic              clk,
    input  logic              reset_top,
    input  logic              clear,        // frame start, zero all words
    input  logic              byte_we,
    input  logic [2:0]        byte_sel,     // 0..5 = xl xh yl yh zl zh
    input  logic [BYTE_W-1:0] byte_in,
    output logic [AXIS_W-1:0] axis_x,
    output logic [AXIS_W-1:0] axis_y,
    output logic [AXIS_W-1:0] axis_z
);

    always_ff @(posedge clk) begin
        if (reset_top || clear) begin
            axis_x <= '0;
            axis_y <= '0;
            axis_z <= '0;
        end else if (byte_we) begin
            case (byte_sel)
                3'd0: axis_x[BYTE_W-1:0]      <= byte_in;   // x low
                3'd1: axis_x[AXIS_W-1:BYTE_W] <= byte_in;   // x high
                3'd2: axis_y[BYTE_W-1:0]      <= byte_in;
                3'd3: axis_y[AXIS_W-1:BYTE_W] <= byte_in;
                3'd4: axis_z[BYTE_W-1:0]      <= byte_in;
                3'd5: axis_z[AXIS_W-1:BYTE_W] <= byte_in;
                default: ;                                  // 6, 7 unused
            endcase
        end
    end

endmodule

// File: rtl/spi_master.sv
`timescale 1ns/100ps

// mode 0 spi master: header out, one data byte back
module spi_master
    import imu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_top,
    spi_cmd_if.master cmd_port,
    output logic      sck,
    output logic      cs_n,
    output logic      mosi,
    input  logic      miso
);

    logic [SHIFT_W-1:0]   tx_sr;       // header then zeros while the byte comes back
    logic [BYTE_W-1:0]    rx_sr;       // miso shift, last 8 bits kept
    logic [BIT_CNT_W-1:0] bits_left;   // bits still to clock, incl. current one
    logic [HALF_W-1:0]    half_cnt;    // clocks within the sck half period
    logic                 tail;        // last falling edge done, waiting to lift cs_n
    logic                 ready_q;

    wire half_end = (half_cnt == HALF_W'(SPI_HALF - 1));
    wire accept   = cmd_port.start & ready_q;     // start while busy is dropped

    assign mosi             = tx_sr[SHIFT_W-1];   // msb first
    assign cmd_port.ready   = ready_q;
    assign cmd_port.rx_byte = rx_sr;

    ////////////////////////////////////////////////////////////////////////////
    // transfer engine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_top) begin
            ready_q   <= 1'b1;
            cs_n      <= 1'b1;
            sck       <= 1'b0;
            tx_sr     <= '0;
            bits_left <= '0;
            half_cnt  <= '0;
            tail      <= 1'b0;
        end else if (accept) begin
            ready_q  <= 1'b0;                  // ready falls next cycle
            cs_n     <= 1'b0;                  // cs_n falls next clock too
            sck      <= 1'b0;
            half_cnt <= '0;
            tail     <= 1'b0;
            if (cmd_port.long_header) begin
                tx_sr     <= {cmd_port.cmd, {BYTE_W{1'b0}}};
                bits_left <= BIT_CNT_W'(SHIFT_W);          // 16 + 8
            end else begin
                // only the upper byte goes out, pad stays behind
                tx_sr     <= {cmd_port.cmd[CMD_W-1 -: BYTE_W], {CMD_W{1'b0}}};
                bits_left <= BIT_CNT_W'(2 * BYTE_W);       // 8 + 8
            end
        end else if (!ready_q) begin
            half_cnt <= half_cnt + 1'b1;
            if (half_end) begin
                half_cnt <= '0;
                if (tail) begin
                    cs_n    <= 1'b1;           // SPI_HALF after last fall
                    ready_q <= 1'b1;           // same clock as cs_n
                    tail    <= 1'b0;
                end else if (!sck) begin
                    sck <= 1'b1;               // rising edge, slave data sampled below
                end else begin
                    sck       <= 1'b0;         // falling edge, next bit onto mosi
                    tx_sr     <= tx_sr << 1;
                    bits_left <= bits_left - 1'b1;
                    if (bits_left == BIT_CNT_W'(1)) begin
                        tail <= 1'b1;
                    end
                end
            end
        end
    end

    // miso capture on the rising sck edge, data phase only
    always_ff @(posedge clk) begin
        if (!ready_q && half_end && !tail && !sck &&
            bits_left <= BIT_CNT_W'(BYTE_W)) begin
            rx_sr <= {rx_sr[BYTE_W-2:0], miso};
        end
    end

endmodule

// File: rtl/poll_tick.sv
`timescale 1ns/100ps

module poll_tick
    import imu_pkg::*;
#(
    parameter int TICK_DIV = TICK_DIV_DEFAULT
) (
    input  logic clk,
    input  logic reset_top,
    output logic tick       // one clk wide, every TICK_DIV clocks
);

    logic [31:0] cnt;       // free running frame divider

    always_ff @(posedge clk) begin
        if (reset_top) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= 1'b0;                       // default low
            if (cnt == 32'(TICK_DIV - 1)) begin
                cnt  <= '0;
                tick <= 1'b1;                   // lands one cycle after terminal count
            end else begin
                cnt <= cnt + 32'd1;
            end
        end
    end

endmodule

// File: rtl/spi_cmd_if.sv
`timescale 1ns/100ps

// sequencer <-> spi master link, plain strobes and levels
interface spi_cmd_if
    import imu_pkg::*;
();

    logic              start;        // one-cycle request, only while ready
    spi_cmd_u          cmd;          // header word, sampled with start
    logic              long_header;  // 1: send 16 header bits, 0: upper 8 only
    logic              ready;        // master idle
    logic [BYTE_W-1:0] rx_byte;      // last byte read, held until next start

    modport seq (
        output start, cmd, long_header,
        input  ready, rx_byte
    );

    modport master (
        input  start, cmd, long_header,
        output ready, rx_byte
    );

endinterface

// File: rtl/imu_pkg.sv
package imu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int AXIS_W     = 16;         // one axis sample
    localparam int BYTE_W     = 8;          // one spi data byte
    localparam int CMD_W      = 16;         // full command word, gyro sends only the top byte
    localparam int AXIS_BYTES = 6;          // xl xh yl yh zl zh
    localparam int SEL_W      = 3;          // byte index / byte_sel width
    localparam int SHIFT_W    = CMD_W + BYTE_W;  // longest transfer, 24 bits
    localparam int BIT_CNT_W  = 5;          // counts up to SHIFT_W

    ////////////////////////////////////////////////////////////////////////////
    // timing
    ////////////////////////////////////////////////////////////////////////////

    localparam int SPI_HALF         = 4;            // clk cycles per sck half period
    localparam int HALF_W           = $clog2(SPI_HALF);
    localparam int TICK_DIV_DEFAULT = 10_000_000;   // 10 Hz frame rate at 100 MHz

    ////////////////////////////////////////////////////////////////////////////
    // sensor register map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] ACCEL_READ_OP   = 8'h0B;  // accel read-register instruction
    localparam logic [7:0] ACCEL_BASE_ADDR = 8'h0E;  // XDATA_L, rest follow in order
    localparam logic [5:0] GYRO_BASE_ADDR  = 6'h28;  // OUT_X_L, rest follow in order

    // poll sequencer states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_WAIT  = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    // command word, same 16 bits seen two ways
    typedef union packed {
        struct packed {
            logic [7:0] opcode;         // first byte on the wire
            logic [7:0] addr;           // register address
        } accel;
        struct packed {
            logic       rd;             // 1 = read
            logic       ms;             // auto-increment, left clear
            logic [5:0] addr;
            logic [7:0] pad;            // never shifted out
        } gyro;
    } spi_cmd_u;

endpackage
